// File: logic/ecc_mem_defines.svh
`ifndef ECC_MEM_DEFINES_SVH
`define ECC_MEM_DEFINES_SVH

// Code geometry.
`define ECC_DATA_WIDTH   21
`define ECC_PARITY_WIDTH 6
`define ECC_CODE_WIDTH   27

// Word index width, 64 words.
`define ECC_MEM_AW 6

`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32

// Register map. Address bit 11 clear selects the memory.
`define REG_CTRL   12'h800
`define REG_INJECT 12'h804
`define REG_STATUS 12'h808

`define SCRUB_PERIOD 256

`endif

// File: logic/ecc_pkg.sv
`include "ecc_mem_defines.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0] ecc_data_t;

    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;

    // Stored parity xor recomputed parity.
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_syndrome_t;

    typedef struct packed {
        ecc_parity_t parity;    // Upper 6 bits.
        ecc_data_t   data;
    } ecc_code_t;

    typedef enum logic [1:0] {
        err_none,
        err_single,
        err_double
    } ecc_err_e;

endpackage

// File: logic/apb_regs_pkg.sv
package apb_regs_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_apb_access,
        st_mem_wait,
        st_read_respond,
        st_scrub_read,
        st_scrub_check,
        st_scrub_write
    } ctrl_state_e;

    typedef enum logic [2:0] {
        op_none,
        op_read,
        op_write,
        op_scrub_read,
        op_scrub_write
    } mem_op_e;

    typedef enum logic [2:0] {
        sel_mem,
        sel_ctrl,
        sel_inject,
        sel_status,
        sel_unmapped
    } reg_sel_e;

endpackage

// File: logic/ecc_mem_if.sv
`include "ecc_mem_defines.svh"

interface ecc_mem_if;
    import ecc_pkg::*;

    logic                   en;
    logic                   we;
    logic [`ECC_MEM_AW-1:0] addr;
    ecc_code_t              wcode;
    ecc_code_t              rcode;    // Valid the cycle after a read.

    modport master (
        output en,
        output we,
        output addr,
        output wcode,
        input  rcode
    );

    modport slave (
        input  en,
        input  we,
        input  addr,
        input  wcode,
        output rcode
    );

endinterface

// File: logic/ecc_21_codec.sv
module ecc_21_codec (
    input  ecc_pkg::ecc_data_t   wdata,
    output ecc_pkg::ecc_parity_t wparity,
    input  ecc_pkg::ecc_code_t   rcode,
    input  logic                 bypass,
    output ecc_pkg::ecc_data_t   rdata,
    output ecc_pkg::ecc_err_e    err
);
    import ecc_pkg::*;

    ecc_syndrome_t syndrome;
    ecc_data_t     flip;
    ecc_err_e      err_raw;

    function automatic ecc_parity_t encode(input ecc_data_t d);
        ecc_parity_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8]
             ^ d[10] ^ d[11] ^ d[13] ^ d[15] ^ d[17] ^ d[19];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9]
             ^ d[10] ^ d[12] ^ d[13] ^ d[16] ^ d[17] ^ d[20];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9]
             ^ d[10] ^ d[14] ^ d[15] ^ d[16] ^ d[17];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9]
             ^ d[10] ^ d[18] ^ d[19] ^ d[20];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15]
             ^ d[16] ^ d[17] ^ d[18] ^ d[19] ^ d[20];
        p[5] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7]
             ^ d[10] ^ d[11] ^ d[12] ^ d[14] ^ d[17] ^ d[18];
        return p;
    endfunction

    assign wparity  = encode(wdata);
    assign syndrome = rcode.parity ^ encode(rcode.data);

    // Syndrome to flipped data bit.
    always_comb begin
        flip    = '0;
        err_raw = err_single;
        case (syndrome)
            6'b000000: err_raw = err_none;
            6'b100011: flip[0] = 1'b1;
            6'b100101: flip[1] = 1'b1;
            6'b100110: flip[2] = 1'b1;
            6'b000111: flip[3] = 1'b1;
            6'b101001: flip[4] = 1'b1;
            6'b101010: flip[5] = 1'b1;
            6'b001011: flip[6] = 1'b1;
            6'b101100: flip[7] = 1'b1;
            6'b001101: flip[8] = 1'b1;
            6'b001110: flip[9] = 1'b1;
            6'b101111: flip[10] = 1'b1;
            6'b110001: flip[11] = 1'b1;
            6'b110010: flip[12] = 1'b1;
            6'b010011: flip[13] = 1'b1;
            6'b110100: flip[14] = 1'b1;
            6'b010101: flip[15] = 1'b1;
            6'b010110: flip[16] = 1'b1;
            6'b110111: flip[17] = 1'b1;
            6'b111000: flip[18] = 1'b1;
            6'b011001: flip[19] = 1'b1;
            6'b011010: flip[20] = 1'b1;
            6'b100000, 6'b010000, 6'b001000,
            6'b000100, 6'b000010, 6'b000001: err_raw = err_single;    // Parity bit only.
            default: err_raw = err_double;
        endcase
    end

    assign rdata = bypass ? rcode.data : rcode.data ^ flip;
    assign err   = bypass ? err_none : err_raw;

    // A corrected data bit must give back a clean codeword.
    a_flip_matches_code: assert final (flip == '0 || encode(rcode.data ^ flip) == rcode.parity);

endmodule

// File: logic/ecc_mem_array.sv
`include "ecc_mem_defines.svh"

module ecc_mem_array (
    input logic      clk,
    input logic      reset,
    ecc_mem_if.slave mem
);
    import ecc_pkg::*;

    localparam int DEPTH = 1 << `ECC_MEM_AW;

    ecc_code_t store [DEPTH];

    // Single port, read data registered.
    always_ff @(posedge clk) begin
        if (mem.en) begin
            if (mem.we) begin
                store[mem.addr] <= mem.wcode;
            end else begin
                mem.rcode <= store[mem.addr];
            end
        end
    end

    a_we_needs_en: assert property (@(posedge clk) disable iff (reset)
        mem.we |-> mem.en);

endmodule

// File: logic/scrub_timer.sv
`include "ecc_mem_defines.svh"

module scrub_timer #(
    parameter int PERIOD = `SCRUB_PERIOD
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   done,
    output logic                   scrub_req,
    output logic [`ECC_MEM_AW-1:0] scrub_addr
);

    localparam int CW = $clog2(PERIOD);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count      <= '0;
            scrub_req  <= 1'b0;
            scrub_addr <= '0;
        end else begin
            if (!enable) begin
                count <= '0;
            end else if (!scrub_req) begin    // Hold while a request waits.
                if (count == CW'(PERIOD - 1)) begin
                    count     <= '0;
                    scrub_req <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
            if (done) begin
                scrub_req  <= 1'b0;
                scrub_addr <= scrub_addr + 1'b1;    // Wraps at 64.
            end
        end
    end

endmodule

// File: logic/ecc_mem_ctrl.sv
`include "ecc_mem_defines.svh"

module ecc_mem_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`APB_DATA_WIDTH-1:0] pwdata,
    output logic [`APB_DATA_WIDTH-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    ecc_mem_if.master                  mem,
    output ecc_pkg::ecc_data_t         enc_data,
    input  ecc_pkg::ecc_parity_t       enc_parity,
    input  ecc_pkg::ecc_data_t         dec_data,
    input  ecc_pkg::ecc_err_e          dec_err,
    output logic                       bypass,
    output logic                       scrub_en,
    input  logic                       scrub_req,
    input  logic [`ECC_MEM_AW-1:0]     scrub_addr,
    output logic                       scrub_done
);
    import ecc_pkg::*;
    import apb_regs_pkg::*;

    localparam int DW = `APB_DATA_WIDTH;

    ctrl_state_e   state;
    ctrl_state_e   state_next;
    mem_op_e       mem_op;
    reg_sel_e      sel;
    logic          access;
    logic          count_en;
    logic [1:0]    ctrl_q;
    ecc_code_t     inject_q;
    ecc_data_t     data_q;
    logic          derr_q;
    logic [7:0]    single_cnt;
    logic [7:0]    double_cnt;
    logic [DW-1:0] reg_rdata;

    assign access   = (state == st_apb_access) && psel && penable;
    assign count_en = (state == st_mem_wait) || (state == st_scrub_check);
    assign bypass   = ctrl_q[0];
    assign scrub_en = ctrl_q[1];

    always_comb begin
        if (!paddr[11]) begin
            sel = sel_mem;
        end else begin
            case (paddr)
                `REG_CTRL:   sel = sel_ctrl;
                `REG_INJECT: sel = sel_inject;
                `REG_STATUS: sel = sel_status;
                default:     sel = sel_unmapped;
            endcase
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (scrub_req) begin
                    state_next = st_scrub_read;    // Scrub wins, APB stretches.
                end else if (psel) begin
                    state_next = st_apb_access;
                end
            end
            st_apb_access: begin
                if (access) begin
                    state_next = (sel == sel_mem && !pwrite) ? st_mem_wait : st_idle;
                end else if (!psel) begin
                    state_next = st_idle;
                end
            end
            st_mem_wait:     state_next = st_read_respond;
            st_read_respond: state_next = st_idle;
            st_scrub_read:   state_next = st_scrub_check;
            st_scrub_check:  state_next = (dec_err == err_single) ? st_scrub_write : st_idle;
            default:         state_next = st_idle;
        endcase
    end

    always_comb begin
        mem_op = op_none;
        case (state)
            st_apb_access: begin
                if (access && sel == sel_mem) begin
                    mem_op = pwrite ? op_write : op_read;
                end
            end
            st_scrub_read:  mem_op = op_scrub_read;
            st_scrub_write: mem_op = op_scrub_write;
            default:        mem_op = op_none;
        endcase
    end

    assign mem.en   = (mem_op != op_none);
    assign mem.we   = (mem_op == op_write) || (mem_op == op_scrub_write);
    assign mem.addr = (mem_op == op_scrub_read || mem_op == op_scrub_write) ?
                      scrub_addr : paddr[`ECC_MEM_AW+1:2];
    assign enc_data = (mem_op == op_scrub_write) ? data_q : pwdata[`ECC_DATA_WIDTH-1:0];

    // Fault mask only hits bus writes.
    assign mem.wcode = (mem_op == op_write) ? ecc_code_t'({enc_parity, enc_data} ^ inject_q) :
                       ecc_code_t'({enc_parity, enc_data});

    assign scrub_done = (state == st_scrub_write) ||
                        (state == st_scrub_check && dec_err != err_single);

    always_comb begin
        case (sel)
            sel_ctrl:   reg_rdata = DW'(ctrl_q);
            sel_inject: reg_rdata = DW'(inject_q);
            sel_status: reg_rdata = DW'({double_cnt, single_cnt});
            default:    reg_rdata = '0;
        endcase
    end

    assign pready  = (access && (sel != sel_mem || pwrite)) || (state == st_read_respond);
    assign prdata  = (state == st_read_respond) ? DW'(data_q) : reg_rdata;
    assign pslverr = (state == st_read_respond) ? derr_q : (access && sel == sel_unmapped);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            ctrl_q     <= '0;
            inject_q   <= '0;
            single_cnt <= '0;
            double_cnt <= '0;
        end else begin
            state <= state_next;
            if (access && pwrite) begin
                case (sel)
                    sel_ctrl:   ctrl_q <= pwdata[1:0];
                    sel_inject: inject_q <= pwdata[`ECC_CODE_WIDTH-1:0];
                    sel_status: begin
                        single_cnt <= '0;
                        double_cnt <= '0;
                    end
                    sel_mem:    inject_q <= '0;    // One shot.
                    default:    ;
                endcase
            end
            if (count_en && dec_err == err_single && single_cnt != 8'hff) begin
                single_cnt <= single_cnt + 8'd1;
            end
            if (count_en && dec_err == err_double && double_cnt != 8'hff) begin
                double_cnt <= double_cnt + 8'd1;
            end
        end
    end

    // Corrected word, for the bus or for writeback.
    always_ff @(posedge clk) begin
        if (count_en) begin
            data_q <= dec_data;
        end
        if (state == st_mem_wait) begin
            derr_q <= (dec_err == err_double);
        end
    end

    a_pready_in_access: assert property (@(posedge clk) disable iff (reset)
        pready |-> psel && penable);

    // Writeback goes to the word that was read.
    a_scrub_write_order: assert property (@(posedge clk) disable iff (reset)
        state == st_scrub_write |->
            $past(state) == st_scrub_check && scrub_addr == $past(scrub_addr, 2));

endmodule

// File: logic/ecc_mem_top.sv
`include "ecc_mem_defines.svh"

module ecc_mem_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`APB_DATA_WIDTH-1:0] pwdata,
    output logic [`APB_DATA_WIDTH-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);
    import ecc_pkg::*;

    ecc_data_t              enc_data;
    ecc_parity_t            enc_parity;
    ecc_data_t              dec_data;
    ecc_err_e               dec_err;
    logic                   bypass;
    logic                   scrub_en;
    logic                   scrub_req;
    logic                   scrub_done;
    logic [`ECC_MEM_AW-1:0] scrub_addr;

    ecc_mem_if mem_bus ();

    ecc_mem_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .mem        (mem_bus.master),
        .enc_data   (enc_data),
        .enc_parity (enc_parity),
        .dec_data   (dec_data),
        .dec_err    (dec_err),
        .bypass     (bypass),
        .scrub_en   (scrub_en),
        .scrub_req  (scrub_req),
        .scrub_addr (scrub_addr),
        .scrub_done (scrub_done)
    );

    scrub_timer #(
        .PERIOD(`SCRUB_PERIOD)
    ) u_scrub (
        .clk        (clk),
        .reset      (reset),
        .enable     (scrub_en),
        .done       (scrub_done),
        .scrub_req  (scrub_req),
        .scrub_addr (scrub_addr)
    );

    // Decodes straight off the array read port.
    ecc_21_codec u_codec (
        .wdata   (enc_data),
        .wparity (enc_parity),
        .rcode   (mem_bus.rcode),
        .bypass  (bypass),
        .rdata   (dec_data),
        .err     (dec_err)
    );

    ecc_mem_array u_array (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.slave)
    );

endmodule

// File: testbench/tb_ecc_mem.sv
`include "ecc_mem_defines.svh"

module tb_ecc_mem;
    timeunit 1ns;
    timeprecision 100ps;

    import ecc_pkg::*;

    localparam int READY_TIMEOUT = 64;
    localparam int POLL_LIMIT    = 2000;

    logic                       clk;
    logic                       reset;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;

    integer      seed = 32'h9303487f;
    int          errors = 0;
    int          checks = 0;
    ecc_parity_t h_col [21];    // Syndrome of each data bit.
    ecc_code_t   model_mem [64];
    logic [7:0]  exp_single = '0;
    logic [7:0]  exp_double = '0;

    // Stimulus table.
    string       t_name [$];
    int          t_idx [$];
    ecc_data_t   t_data [$];
    ecc_code_t   t_mask [$];
    logic        t_bypass [$];
    logic        t_write [$];
    ecc_data_t   t_exp_data [$];
    ecc_err_e    t_exp_class [$];
    logic [7:0]  t_exp_single [$];
    logic [7:0]  t_exp_double [$];

    ecc_mem_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic ecc_parity_t ref_parity(input ecc_data_t d);
        ecc_parity_t p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ h_col[i];
            end
        end
        return p;
    endfunction

    function automatic ecc_err_e ref_decode(input ecc_code_t c, output ecc_data_t fixed);
        ecc_syndrome_t syn;
        ecc_err_e      cls;
        syn   = c.parity ^ ref_parity(c.data);
        fixed = c.data;
        cls   = err_double;
        if (syn == '0) begin
            cls = err_none;
        end else if ((syn & (syn - 1'b1)) == '0) begin
            cls = err_single;    // Check bit hit.
        end else begin
            for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
                if (h_col[i] == syn) begin
                    fixed[i] = ~fixed[i];
                    cls      = err_single;
                end
            end
        end
        return cls;
    endfunction

    // Class seen on the bus from pslverr and the single count step.
    function automatic ecc_err_e observed_class(input logic slverr, input logic [7:0] ds);
        if (slverr) begin
            return err_double;
        end else if (ds != 8'd0) begin
            return err_single;
        end
        return err_none;
    endfunction

    function automatic logic [`APB_ADDR_WIDTH-1:0] word_addr(input int idx);
        return `APB_ADDR_WIDTH'(idx << 2);
    endfunction

    task automatic add_entry(input string name, input int idx, input ecc_data_t data,
                             input ecc_code_t mask, input logic bypass, input logic write);
        ecc_data_t fixed;
        ecc_err_e  cls;
        if (write) begin
            model_mem[idx] = ecc_code_t'({ref_parity(data), data} ^ mask);
        end
        cls = ref_decode(model_mem[idx], fixed);
        if (bypass) begin
            cls   = err_none;
            fixed = model_mem[idx].data;
        end
        if (cls == err_single) exp_single = exp_single + 8'd1;
        if (cls == err_double) exp_double = exp_double + 8'd1;
        t_name.push_back(name);
        t_idx.push_back(idx);
        t_data.push_back(data);
        t_mask.push_back(mask);
        t_bypass.push_back(bypass);
        t_write.push_back(write);
        t_exp_data.push_back(fixed);
        t_exp_class.push_back(cls);
        t_exp_single.push_back(exp_single);
        t_exp_double.push_back(exp_double);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic apb_transfer(input logic wr, input logic [`APB_ADDR_WIDTH-1:0] addr,
                                input logic [`APB_DATA_WIDTH-1:0] wdata,
                                output logic [`APB_DATA_WIDTH-1:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (!pready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("No pready within %0d cycles for address %h", READY_TIMEOUT, addr);
            errors++;
            finish_run();
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input logic [`APB_DATA_WIDTH-1:0] wdata);
        logic [`APB_DATA_WIDTH-1:0] unused;
        logic                       err;
        apb_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [`APB_ADDR_WIDTH-1:0] addr,
                            output logic [`APB_DATA_WIDTH-1:0] rdata, output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic check_data(input string name, input ecc_data_t exp, input ecc_data_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_class(input string name, input ecc_err_e exp, input ecc_err_e act);
        checks++;
        if (exp !== act) begin
            $display("ERROR %s: expected class %0d, actual class %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic verify_count(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic match_code(input string name, input ecc_code_t exp, input ecc_code_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Read with status around it.
    task automatic read_classified(input int idx, output logic [`APB_DATA_WIDTH-1:0] rd,
                                   output ecc_err_e cls, output logic [7:0] single_cnt,
                                   output logic [7:0] double_cnt);
        logic [`APB_DATA_WIDTH-1:0] s0;
        logic [`APB_DATA_WIDTH-1:0] s1;
        logic                       slv;
        logic                       dummy;
        apb_read(`REG_STATUS, s0, dummy);
        apb_read(word_addr(idx), rd, slv);
        apb_read(`REG_STATUS, s1, dummy);
        cls        = observed_class(slv, s1[7:0] - s0[7:0]);
        single_cnt = s1[7:0];
        double_cnt = s1[15:8];
    endtask

    initial begin
        logic [`APB_DATA_WIDTH-1:0] rd;
        logic                       slv;
        logic [7:0]                 sc;
        logic [7:0]                 dc;
        ecc_err_e                   cls;
        ecc_data_t                  d;
        ecc_data_t                  scrub_data [64];
        int                         w;
        int                         b1;
        int                         b2;
        int                         polls;
        int                         target;

        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        h_col = '{6'b100011, 6'b100101, 6'b100110, 6'b000111, 6'b101001, 6'b101010,
                  6'b001011, 6'b101100, 6'b001101, 6'b001110, 6'b101111, 6'b110001,
                  6'b110010, 6'b010011, 6'b110100, 6'b010101, 6'b010110, 6'b110111,
                  6'b111000, 6'b011001, 6'b011010};

        w = 0;
        for (int i = 0; i < 4; i++) begin
            add_entry($sformatf("clean_%0d", i), w, ecc_data_t'($random(seed)), '0, 1'b0, 1'b1);
            w++;
        end
        for (int b = 0; b < `ECC_CODE_WIDTH; b++) begin
            add_entry($sformatf("single_bit%0d", b), w, ecc_data_t'($random(seed)),
                      ecc_code_t'(27'd1 << b), 1'b0, 1'b1);
            if (b == 0 || b == 21) begin
                add_entry($sformatf("reread_bit%0d", b), w, '0, '0, 1'b0, 1'b0);
            end
            w++;
        end
        for (int i = 0; i < 4; i++) begin
            b1 = {$random(seed)} % 27;
            b2 = (b1 + 1 + {$random(seed)} % 26) % 27;
            add_entry($sformatf("double_%0d_%0d", b1, b2), w, ecc_data_t'($random(seed)),
                      ecc_code_t'((27'd1 << b1) | (27'd1 << b2)), 1'b0, 1'b1);
            w++;
        end
        for (int i = 0; i < 3; i++) begin
            b1 = {$random(seed)} % 21;
            add_entry($sformatf("bypass_bit%0d", b1), w, ecc_data_t'($random(seed)),
                      ecc_code_t'(27'd1 << b1), 1'b1, 1'b1);
            w++;
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < t_name.size(); i++) begin
            apb_write(`REG_CTRL, {31'd0, t_bypass[i]});
            if (t_write[i]) begin
                if (t_mask[i] != '0) begin
                    apb_write(`REG_INJECT, 32'(t_mask[i]));
                end
                apb_write(word_addr(t_idx[i]), 32'(t_data[i]));
            end
            read_classified(t_idx[i], rd, cls, sc, dc);
            compare_class(t_name[i], t_exp_class[i], cls);
            if (t_exp_class[i] != err_double) begin
                check_data(t_name[i], t_exp_data[i], rd[`ECC_DATA_WIDTH-1:0]);
            end
            verify_count({t_name[i], "_single_cnt"}, t_exp_single[i], sc);
            verify_count({t_name[i], "_double_cnt"}, t_exp_double[i], dc);
        end
        apb_write(`REG_CTRL, 32'd0);

        // Status clear and one-shot inject.
        apb_write(`REG_STATUS, 32'd0);
        apb_read(`REG_STATUS, rd, slv);
        verify_count("status_clear_single", 8'd0, rd[7:0]);
        verify_count("status_clear_double", 8'd0, rd[15:8]);
        apb_write(`REG_INJECT, 32'd1 << 7);
        apb_read(`REG_INJECT, rd, slv);
        match_code("inject_readback", ecc_code_t'(27'd1 << 7), rd[`ECC_CODE_WIDTH-1:0]);
        d = ecc_data_t'($random(seed));
        apb_write(word_addr(50), 32'(d));
        apb_read(`REG_INJECT, rd, slv);
        match_code("inject_one_shot", '0, rd[`ECC_CODE_WIDTH-1:0]);
        read_classified(50, rd, cls, sc, dc);
        compare_class("inject_applied", err_single, cls);
        check_data("inject_applied", d, rd[`ECC_DATA_WIDTH-1:0]);

        // Scrub repair of one word.
        target = 9;
        apb_write(`REG_STATUS, 32'd0);
        for (int i = 0; i < 64; i++) begin
            scrub_data[i] = ecc_data_t'($random(seed));
            if (i == target) begin
                apb_write(`REG_INJECT, 32'd1 << 4);
            end
            apb_write(word_addr(i), 32'(scrub_data[i]));
        end
        apb_write(`REG_CTRL, 32'd2);
        polls = 0;
        apb_read(`REG_STATUS, rd, slv);
        while (rd[7:0] == 8'd0 && polls < POLL_LIMIT) begin
            apb_read(`REG_STATUS, rd, slv);
            polls++;
        end
        if (rd[7:0] == 8'd0) begin
            $display("Scrubber found no error after %0d status polls", POLL_LIMIT);
            errors++;
        end else begin
            apb_write(`REG_CTRL, 32'd0);
            read_classified(target, rd, cls, sc, dc);
            compare_class("scrub_repair", err_none, cls);
            check_data("scrub_repair", scrub_data[target], rd[`ECC_DATA_WIDTH-1:0]);
            verify_count("scrub_single_cnt", 8'd1, sc);
            verify_count("scrub_double_cnt", 8'd0, dc);
        end

        finish_run();
    end

endmodule

// File: sim.f
+incdir+logic
logic/ecc_pkg.sv
logic/apb_regs_pkg.sv
logic/ecc_mem_if.sv
logic/ecc_21_codec.sv
logic/ecc_mem_array.sv
logic/scrub_timer.sv
logic/ecc_mem_ctrl.sv
logic/ecc_mem_top.sv
testbench/tb_ecc_mem.sv
